// ==== Makefile ====
TOP = rename_tb

all: run

build:
	verilator --binary --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// ==== branch_stack/branch_stack.sv ====
`timescale 1ns/1ps

module branch_stack
    import rename_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    dispatch_if.stack   disp,
    input  checkpoint_t snap,
    input  logic        cdb_valid,
    input  arch_idx_t   cdb_arch,
    input  phys_idx_t   cdb_phys,
    input  br_task_t    br_task,
    input  b_id_t       rem_b_id,
    output checkpoint_t cp_out,
    output logic        full,
    output b_id_t       live_ids
);

    checkpoint_t [branch_depth-1:0] entries;
    checkpoint_t [branch_depth-1:0] next_entries;
    b_id_t                          gnt;
    logic                           take;

    // lowest free entry wins, walking down so the last hit is the lowest
    always_comb begin
        gnt = '0;
        for (int i = branch_depth - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                gnt = b_id_t'(1) << i;
            end
        end
    end

    always_comb begin
        live_ids = '0;
        full     = 1'b1;
        for (int i = 0; i < branch_depth; i++) begin
            if (entries[i].valid) begin
                live_ids = live_ids | entries[i].b_id;
            end
            full = full & entries[i].valid;
        end
    end

    assign take           = disp.fire && disp.pkt.is_branch;
    assign disp.b_id      = (disp.pkt.valid && disp.pkt.is_branch) ? gnt : '0;
    assign disp.live_mask = live_ids;

    always_comb begin
        cp_out = '0;
        for (int i = 0; i < branch_depth; i++) begin
            if (entries[i].valid && entries[i].b_id == rem_b_id) begin
                cp_out = entries[i];
            end
        end
    end

    always_comb begin
        next_entries = entries;
        for (int i = 0; i < branch_depth; i++) begin
            if (br_task == CLEAR) begin
                if (entries[i].b_id == rem_b_id) begin
                    next_entries[i].valid = 1'b0;
                end else begin
                    next_entries[i].b_mask = entries[i].b_mask & ~rem_b_id;
                end
            end else if (br_task == SQUASH) begin
                // the squashed branch and everything younger that depends on it
                if (entries[i].b_id == rem_b_id || (entries[i].b_mask & rem_b_id) != '0) begin
                    next_entries[i].valid = 1'b0;
                end
            end

            if (take && gnt[i]) begin
                next_entries[i]        = snap;
                next_entries[i].valid  = 1'b1;
                next_entries[i].b_id   = gnt;
                next_entries[i].b_mask = live_ids;
                next_entries[i].rec_pc = disp.pkt.pc + 32'd4;
            end

            // wakeup also covers a checkpoint written on this edge
            if (cdb_valid && next_entries[i].valid &&
                next_entries[i].rec_mt[cdb_arch].phys == cdb_phys) begin
                next_entries[i].rec_mt[cdb_arch].ready = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < branch_depth; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            entries <= next_entries;
        end
    end

endmodule

// ==== common/dispatch_if.sv ====
`timescale 1ns/1ps

interface dispatch_if
    import rename_pkg::*;
();

    decoded_packet_t pkt;
    logic            stall;
    logic            fire;
    b_id_t           b_id;      // id for the branch in pkt, zero otherwise
    b_id_t           live_mask;

    modport decoder (
        output pkt,
        output fire,
        input  stall
    );

    modport renamer (
        input  pkt,
        input  fire,
        input  b_id,
        input  live_mask,
        output stall
    );

    modport stack (
        input  pkt,
        input  fire,
        output b_id,
        output live_mask
    );

endinterface

// ==== common/rename_pkg.sv ====
package rename_pkg;

    localparam int arch_regs    = 8;
    localparam int phys_regs    = 32;
    localparam int branch_depth = 4;
    localparam int rob_size     = 16;
    localparam int fl_size      = phys_regs - arch_regs; // registers free at reset

    // RISC-V opcodes handled by the decoder
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    typedef logic [$clog2(arch_regs)-1:0] arch_idx_t;
    typedef logic [$clog2(phys_regs)-1:0] phys_idx_t;
    typedef logic [branch_depth-1:0]      b_id_t;     // one-hot
    typedef logic [$clog2(rob_size)-1:0]  rob_idx_t;
    typedef logic [$clog2(fl_size)-1:0]   fl_ptr_t;   // counts modulo fl_size

    typedef enum logic [1:0] {
        NOP,
        CLEAR,
        SQUASH
    } br_task_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        arch_idx_t   dest;
        arch_idx_t   src1;
        arch_idx_t   src2;
        logic        has_dest;
        logic        is_branch; // cond or uncond
    } decoded_packet_t;

    typedef struct packed {
        phys_idx_t phys;
        logic      ready;
    } map_entry_t;

    typedef struct packed {
        logic                         valid;
        b_id_t                        b_id;
        b_id_t                        b_mask;  // older branches this one depends on
        logic [31:0]                  rec_pc;
        map_entry_t [arch_regs-1:0]   rec_mt;
        fl_ptr_t                      fl_head;
        rob_idx_t                     rob_tail;
    } checkpoint_t;

endpackage

// ==== list.f ====
common/rename_pkg.sv
common/dispatch_if.sv
logic/inst_decode.sv
logic/rename_core.sv
branch_stack/branch_stack.sv
logic/branch_resolve.sv
logic/rename_top.sv
test/rename_chk.sv
test/rename_tb.sv

// ==== logic/branch_resolve.sv ====
`timescale 1ns/1ps

module branch_resolve
    import rename_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        res_valid,
    input  b_id_t       res_b_id,
    input  logic        res_mispredict,
    input  b_id_t       live_ids,
    input  checkpoint_t cp_out,
    output br_task_t    br_task,
    output b_id_t       rem_b_id,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    logic  req_q;
    logic  mispredict_q;
    b_id_t id_q;
    logic  live_hit;

    always_ff @(posedge clock) begin
        if (reset) begin
            req_q <= 1'b0;
        end else begin
            req_q <= res_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (res_valid) begin
            id_q         <= res_b_id;
            mispredict_q <= res_mispredict;
        end
    end

    // checked against the ids live now, so one freed by the last task is dropped
    assign live_hit = req_q && ((id_q & live_ids) != '0);

    always_comb begin
        br_task = NOP;
        if (live_hit) begin
            br_task = mispredict_q ? SQUASH : CLEAR;
        end
    end

    assign rem_b_id       = id_q;
    assign redirect_valid = (br_task == SQUASH);
    assign redirect_pc    = cp_out.rec_pc; // branch pc plus 4

endmodule

// ==== logic/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode
    import rename_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        in_valid,
    input  logic [31:0] in_inst,
    input  logic [31:0] in_pc,
    output logic        in_ready,
    dispatch_if.decoder disp
);

    decoded_packet_t dec_d;
    decoded_packet_t dec_q;
    logic            valid_q;
    logic [6:0]      opcode;

    assign opcode   = in_inst[6:0];
    assign in_ready = !(valid_q && disp.stall); // blocked only by a held packet

    // only the low bits of each register field name one of the arch regs
    always_comb begin
        dec_d           = '0;
        dec_d.pc        = in_pc;
        dec_d.dest      = in_inst[7 +: $bits(arch_idx_t)];
        dec_d.src1      = in_inst[15 +: $bits(arch_idx_t)];
        dec_d.src2      = in_inst[20 +: $bits(arch_idx_t)];
        dec_d.has_dest  = opcode inside {opc_op, opc_op_imm, opc_jal};
        dec_d.is_branch = opcode inside {opc_branch, opc_jal};
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_ready && in_valid) begin
            dec_q <= dec_d;
        end
    end

    always_comb begin
        disp.pkt       = dec_q;
        disp.pkt.valid = valid_q;
    end

    assign disp.fire = valid_q && !disp.stall;

endmodule

// ==== logic/rename_core.sv ====
`timescale 1ns/1ps

module rename_core
    import rename_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    dispatch_if.renamer disp,
    input  logic        stack_full,
    input  br_task_t    br_task,
    input  checkpoint_t cp_out,
    input  logic        cdb_valid,
    input  arch_idx_t   cdb_arch,
    input  phys_idx_t   cdb_phys,
    output checkpoint_t snap,
    output logic        out_valid,
    output logic [31:0] out_pc,
    output phys_idx_t   out_dest_phys,
    output phys_idx_t   out_src1_phys,
    output phys_idx_t   out_src2_phys,
    output logic        out_src1_ready,
    output logic        out_src2_ready,
    output rob_idx_t    out_rob_idx,
    output b_id_t       out_b_id,
    output b_id_t       out_b_mask
);

    map_entry_t [arch_regs-1:0] map_mt;
    map_entry_t [arch_regs-1:0] next_mt;
    phys_idx_t                  fl_mem [fl_size];
    fl_ptr_t                    fl_head;
    logic                       fl_empty;
    logic                       head_wrap;
    rob_idx_t                   rob_tail;
    logic                       alloc;

    assign alloc     = disp.fire && disp.pkt.has_dest;
    assign head_wrap = (fl_head == fl_ptr_t'(fl_size - 1));

    assign disp.stall = stack_full || fl_empty || (br_task != NOP);

    // free list contents, loaded at reset with phys regs above the arch ones
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < fl_size; i++) begin
                fl_mem[i] <= phys_idx_t'(arch_regs + i);
            end
        end
    end

    // restore first, then wakeup, then the new mapping
    always_comb begin
        next_mt = (br_task == SQUASH) ? cp_out.rec_mt : map_mt;
        if (cdb_valid && next_mt[cdb_arch].phys == cdb_phys) begin
            next_mt[cdb_arch].ready = 1'b1;
        end
        if (alloc) begin
            next_mt[disp.pkt.dest] = '{phys: fl_mem[fl_head], ready: 1'b0};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < arch_regs; i++) begin
                map_mt[i] <= '{phys: phys_idx_t'(i), ready: 1'b1};
            end
            fl_head   <= '0;
            fl_empty  <= 1'b0;
            rob_tail  <= '0;
            out_valid <= 1'b0;
        end else begin
            map_mt    <= next_mt;
            out_valid <= disp.fire;
            if (br_task == SQUASH) begin
                fl_head  <= cp_out.fl_head;
                fl_empty <= 1'b0; // checkpoints are never taken with an empty list
                rob_tail <= cp_out.rob_tail;
            end else if (disp.fire) begin
                rob_tail <= rob_tail + 1'b1;
                if (disp.pkt.has_dest) begin
                    fl_head  <= head_wrap ? '0 : fl_head + 1'b1;
                    fl_empty <= head_wrap;
                end
            end
        end
    end

    // sources read the map before this instruction's own write
    always_ff @(posedge clock) begin
        if (disp.fire) begin
            out_pc         <= disp.pkt.pc;
            out_dest_phys  <= disp.pkt.has_dest ? fl_mem[fl_head] : '0;
            out_src1_phys  <= map_mt[disp.pkt.src1].phys;
            out_src2_phys  <= map_mt[disp.pkt.src2].phys;
            out_src1_ready <= map_mt[disp.pkt.src1].ready;
            out_src2_ready <= map_mt[disp.pkt.src2].ready;
            out_rob_idx    <= rob_tail;
            out_b_id       <= disp.b_id;
            out_b_mask     <= disp.live_mask;
        end
    end

    always_comb begin
        snap          = '0;
        snap.rec_mt   = map_mt;
        snap.fl_head  = fl_head;
        snap.rob_tail = rob_tail;
    end

endmodule

// ==== logic/rename_top.sv ====
`timescale 1ns/1ps

module rename_top
    import rename_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        in_valid,
    input  logic [31:0] in_inst,
    input  logic [31:0] in_pc,
    output logic        in_ready,
    input  logic        res_valid,
    input  b_id_t       res_b_id,
    input  logic        res_mispredict,
    input  logic        cdb_valid,
    input  arch_idx_t   cdb_arch,
    input  phys_idx_t   cdb_phys,
    output logic        out_valid,
    output logic [31:0] out_pc,
    output phys_idx_t   out_dest_phys,
    output phys_idx_t   out_src1_phys,
    output phys_idx_t   out_src2_phys,
    output logic        out_src1_ready,
    output logic        out_src2_ready,
    output rob_idx_t    out_rob_idx,
    output b_id_t       out_b_id,
    output b_id_t       out_b_mask,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc,
    output logic        stack_full
);

    checkpoint_t snap;
    checkpoint_t cp_out;
    br_task_t    br_task;
    b_id_t       rem_b_id;
    b_id_t       live_ids;

    dispatch_if disp ();

    inst_decode u_decode (
        .clock    (clock),
        .reset    (reset),
        .in_valid (in_valid),
        .in_inst  (in_inst),
        .in_pc    (in_pc),
        .in_ready (in_ready),
        .disp     (disp.decoder)
    );

    rename_core u_rename (
        .clock          (clock),
        .reset          (reset),
        .disp           (disp.renamer),
        .stack_full     (stack_full),
        .br_task        (br_task),
        .cp_out         (cp_out),
        .cdb_valid      (cdb_valid),
        .cdb_arch       (cdb_arch),
        .cdb_phys       (cdb_phys),
        .snap           (snap),
        .out_valid      (out_valid),
        .out_pc         (out_pc),
        .out_dest_phys  (out_dest_phys),
        .out_src1_phys  (out_src1_phys),
        .out_src2_phys  (out_src2_phys),
        .out_src1_ready (out_src1_ready),
        .out_src2_ready (out_src2_ready),
        .out_rob_idx    (out_rob_idx),
        .out_b_id       (out_b_id),
        .out_b_mask     (out_b_mask)
    );

    branch_stack u_stack (
        .clock     (clock),
        .reset     (reset),
        .disp      (disp.stack),
        .snap      (snap),
        .cdb_valid (cdb_valid),
        .cdb_arch  (cdb_arch),
        .cdb_phys  (cdb_phys),
        .br_task   (br_task),
        .rem_b_id  (rem_b_id),
        .cp_out    (cp_out),
        .full      (stack_full),
        .live_ids  (live_ids)
    );

    branch_resolve u_resolve (
        .clock          (clock),
        .reset          (reset),
        .res_valid      (res_valid),
        .res_b_id       (res_b_id),
        .res_mispredict (res_mispredict),
        .live_ids       (live_ids),
        .cp_out         (cp_out),
        .br_task        (br_task),
        .rem_b_id       (rem_b_id),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

// ==== test/rename_chk.sv ====
`timescale 1ns/1ps

module rename_chk
    import rename_pkg::*;
(
    input logic                           clock,
    input logic                           reset,
    input checkpoint_t [branch_depth-1:0] entries,
    input logic                           full,
    input b_id_t                          live_ids,
    input br_task_t                       br_task,
    input logic                           fire
);

    int n_valid;

    always_comb begin
        n_valid = 0;
        for (int i = 0; i < branch_depth; i++) begin
            n_valid += int'(entries[i].valid);
        end
    end

    // distinct one-hot ids, so the OR keeps one bit per live checkpoint
    assert property (@(posedge clock) disable iff (reset) $countones(live_ids) == n_valid)
        else $error("live branch ids overlap");

    // a full stack stalls dispatch
    assert property (@(posedge clock) disable iff (reset) full |-> !fire)
        else $error("rename fired while the stack is full");

    // no rename starts in a squash cycle, so no out_valid follows from it
    assert property (@(posedge clock) disable iff (reset) br_task == SQUASH |-> !fire)
        else $error("rename fired during a squash");

endmodule

bind branch_stack rename_chk chk (
    .clock    (clock),
    .reset    (reset),
    .entries  (entries),
    .full     (full),
    .live_ids (live_ids),
    .br_task  (br_task),
    .fire     (disp.fire)
);

// ==== test/rename_tb.sv ====
`timescale 1ns/1ps

module rename_tb
    import rename_pkg::*;
();

    localparam logic [1:0] k_inst = 2'd0;
    localparam logic [1:0] k_res  = 2'd1;
    localparam logic [1:0] k_cdb  = 2'd2;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] data;  // instruction word, resolve id, or arch and phys of a result
        logic        misp;
        logic        hold;  // instruction expected to wait in decode
        logic [3:0]  exp;   // branch id of an instruction, redirect of a resolve
    } entry_t;

    logic        clock;
    logic        reset;
    logic        in_valid;
    logic [31:0] in_inst;
    logic [31:0] in_pc;
    logic        in_ready;
    logic        res_valid;
    b_id_t       res_b_id;
    logic        res_mispredict;
    logic        cdb_valid;
    arch_idx_t   cdb_arch;
    phys_idx_t   cdb_phys;
    logic        out_valid;
    logic [31:0] out_pc;
    phys_idx_t   out_dest_phys;
    phys_idx_t   out_src1_phys;
    phys_idx_t   out_src2_phys;
    logic        out_src1_ready;
    logic        out_src2_ready;
    rob_idx_t    out_rob_idx;
    b_id_t       out_b_id;
    b_id_t       out_b_mask;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        stack_full;

    // reference state of the live map, free-list head, rob tail and checkpoints by slot
    phys_idx_t [arch_regs-1:0] m_phys;
    logic [arch_regs-1:0]      m_rdy;
    int                        m_head;
    int                        m_tail;
    logic                      c_valid [branch_depth];
    b_id_t                     c_mask  [branch_depth];
    phys_idx_t [arch_regs-1:0] c_phys  [branch_depth];
    logic [arch_regs-1:0]      c_rdy   [branch_depth];
    int                        c_head  [branch_depth];
    int                        c_tail  [branch_depth];
    logic [31:0]               c_pc    [branch_depth];

    entry_t      stim[$];
    string       kind_name [3] = '{"instruction", "resolve", "result bus"};
    logic [31:0] pc_next;
    logic        held;
    logic [31:0] held_word;
    logic [31:0] held_pc;
    b_id_t       held_id;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 0;

    rename_top uut (.*);

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: no response from the DUT after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] alu(input int rd, input int rs1, input int rs2);
        return {7'b0, 5'(rs2), 5'(rs1), 3'b0, 5'(rd), opc_op};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1);
        return {12'd0, 5'(rs1), 3'b0, 5'(rd), opc_op_imm};
    endfunction

    function automatic logic [31:0] beq(input int rs1, input int rs2);
        return {7'b0, 5'(rs2), 5'(rs1), 3'b0, 5'b0, opc_branch};
    endfunction

    function automatic b_id_t live_mask();
        b_id_t m;
        m = '0;
        for (int i = 0; i < branch_depth; i++) begin
            if (c_valid[i]) m[i] = 1'b1;
        end
        return m;
    endfunction

    task automatic push_entry(input logic [1:0] kind, input logic [31:0] data, input logic misp,
                              input logic hold, input logic [3:0] exp);
        stim.push_back(entry_t'{kind, data, misp, hold, exp});
    endtask

    // compares one renamed instruction, then advances the reference state
    task automatic check_rename(input logic [31:0] word, input logic [31:0] pc,
                                input b_id_t exp_id);
        logic [6:0] opc;
        arch_idx_t  rd;
        arch_idx_t  rs1;
        arch_idx_t  rs2;
        b_id_t      id;
        int         slot;
        opc  = word[6:0];
        rd   = word[9:7];
        rs1  = word[17:15];
        rs2  = word[22:20];
        id   = '0;
        slot = -1;
        compare("out pc", out_pc, pc);
        compare("src1 phys", out_src1_phys, m_phys[rs1]);
        compare("src1 ready", out_src1_ready, m_rdy[rs1]);
        if (opc == opc_op || opc == opc_branch) begin
            compare("src2 phys", out_src2_phys, m_phys[rs2]);
            compare("src2 ready", out_src2_ready, m_rdy[rs2]);
        end
        compare("rob index", out_rob_idx, m_tail % rob_size);
        compare("branch mask", out_b_mask, live_mask());
        if (opc == opc_branch || opc == opc_jal) begin
            for (int i = 0; i < branch_depth; i++) begin
                if (slot < 0 && !c_valid[i]) slot = i;
            end
            if (slot >= 0) begin
                id            = b_id_t'(1 << slot);
                c_mask[slot]  = live_mask();
                c_valid[slot] = 1'b1;
                c_phys[slot]  = m_phys; // taken before this branch's own destination
                c_rdy[slot]   = m_rdy;
                c_head[slot]  = m_head;
                c_tail[slot]  = m_tail;
                c_pc[slot]    = pc + 32'd4;
            end
        end
        compare("branch id", out_b_id, id);
        compare("branch id from table", out_b_id, exp_id);
        if (opc == opc_op || opc == opc_op_imm || opc == opc_jal) begin
            compare("dest phys", out_dest_phys, arch_regs + m_head);
            m_phys[rd] = phys_idx_t'(arch_regs + m_head);
            m_rdy[rd]  = 1'b0;
            m_head     = (m_head + 1) % fl_size;
        end
        m_tail++;
    endtask

    task automatic issue(input logic [31:0] word, input logic hold, input b_id_t exp_id);
        @(negedge clock);
        in_valid = 1'b1;
        in_inst  = word;
        in_pc    = pc_next;
        while (!in_ready) @(negedge clock);
        @(negedge clock);
        in_valid = 1'b0;
        if (hold) begin
            compare("stack full", stack_full, 1);
            compare("in ready", in_ready, 0);
            @(negedge clock);
            compare("out valid while held", out_valid, 0);
            held      = 1'b1;
            held_word = word;
            held_pc   = pc_next;
            held_id   = exp_id;
        end else begin
            while (!out_valid) @(negedge clock);
            check_rename(word, pc_next, exp_id);
        end
        pc_next += 32'd4;
    endtask

    task automatic apply_resolve(input b_id_t id, input logic misp, input logic exp_redirect);
        int slot;
        slot = -1;
        for (int i = 0; i < branch_depth; i++) begin
            if (c_valid[i] && id == b_id_t'(1 << i)) slot = i;
        end
        @(negedge clock);
        res_valid      = 1'b1;
        res_b_id       = id;
        res_mispredict = misp;
        @(negedge clock);
        res_valid = 1'b0;
        compare("redirect valid", redirect_valid, (slot >= 0) && misp);
        compare("redirect valid from table", redirect_valid, exp_redirect);
        if (slot >= 0 && misp) begin
            compare("redirect pc", redirect_pc, c_pc[slot]);
            m_phys  = c_phys[slot];
            m_rdy   = c_rdy[slot];
            m_head  = c_head[slot];
            m_tail  = c_tail[slot];
            pc_next = c_pc[slot];
            for (int j = 0; j < branch_depth; j++) begin
                if (c_mask[j][slot]) c_valid[j] = 1'b0; // younger dependents go too
            end
            c_valid[slot] = 1'b0;
        end else if (slot >= 0) begin
            c_valid[slot] = 1'b0;
            for (int j = 0; j < branch_depth; j++) begin
                c_mask[j][slot] = 1'b0;
            end
        end
    endtask

    task automatic apply_cdb(input arch_idx_t a, input phys_idx_t p);
        @(negedge clock);
        cdb_valid = 1'b1;
        cdb_arch  = a;
        cdb_phys  = p;
        @(negedge clock);
        cdb_valid = 1'b0;
        if (m_phys[a] == p) m_rdy[a] = 1'b1;
        for (int i = 0; i < branch_depth; i++) begin
            if (c_valid[i] && c_phys[i][a] == p) c_rdy[i][a] = 1'b1;
        end
    endtask

    initial begin
        int c0;
        int e0;
        clock = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_inst = '0;
        in_pc = '0;
        res_valid = 1'b0;
        res_b_id = '0;
        res_mispredict = 1'b0;
        cdb_valid = 1'b0;
        cdb_arch = '0;
        cdb_phys = '0;
        for (int i = 0; i < arch_regs; i++) begin
            m_phys[i] = phys_idx_t'(i);
        end
        m_rdy   = '1;
        m_head  = 0;
        m_tail  = 0;
        c_valid = '{default: 1'b0};
        held    = 1'b0;
        pc_next = 32'h1000;

        push_entry(k_inst, alu(1, 2, 3), 0, 0, 0);
        push_entry(k_inst, alu(2, 1, 0), 0, 0, 0);   // reads x1 while in flight
        push_entry(k_inst, addi(3, 2), 0, 0, 0);
        push_entry(k_cdb, (1 << 8) | 8, 0, 0, 0);
        push_entry(k_inst, alu(4, 1, 2), 0, 0, 0);
        push_entry(k_inst, beq(1, 4), 0, 0, 4'b0001);
        push_entry(k_inst, alu(5, 2, 3), 0, 0, 0);
        push_entry(k_inst, beq(5, 0), 0, 0, 4'b0010);
        push_entry(k_cdb, (2 << 8) | 9, 0, 0, 0);    // lands in both checkpoints
        push_entry(k_inst, alu(6, 2, 5), 0, 0, 0);
        push_entry(k_res, 4'b0001, 0, 0, 0);
        push_entry(k_inst, beq(6, 6), 0, 0, 4'b0001);
        push_entry(k_inst, alu(7, 6, 1), 0, 0, 0);
        push_entry(k_res, 4'b0010, 1, 0, 1);
        push_entry(k_inst, alu(5, 2, 5), 0, 0, 0);
        push_entry(k_res, 4'b0100, 1, 0, 0);         // id not live
        push_entry(k_inst, beq(5, 2), 0, 0, 4'b0001);
        push_entry(k_inst, alu(3, 5, 2), 0, 0, 0);
        push_entry(k_inst, beq(3, 1), 0, 0, 4'b0010);
        push_entry(k_inst, beq(0, 0), 0, 0, 4'b0100);
        push_entry(k_inst, beq(3, 3), 0, 0, 4'b1000);
        push_entry(k_inst, beq(1, 1), 0, 1, 4'b0010); // fifth branch waits
        push_entry(k_res, 4'b0010, 0, 0, 0);
        push_entry(k_res, 4'b0010, 1, 0, 1);
        push_entry(k_inst, beq(2, 3), 0, 0, 4'b0010);
        push_entry(k_res, 4'b0001, 1, 0, 1);
        push_entry(k_inst, alu(2, 3, 5), 0, 0, 0);
        limit = 20 * stim.size() + 3;

        repeat (3) @(negedge clock);
        reset = 1'b0;

        foreach (stim[n]) begin
            c0 = checks;
            e0 = errors;
            case (stim[n].kind)
                k_inst: issue(stim[n].data, stim[n].hold, stim[n].exp);
                k_res: begin
                    apply_resolve(stim[n].data[3:0], stim[n].misp, stim[n].exp[0]);
                    if (held) begin
                        while (!out_valid) @(negedge clock);
                        held = 1'b0;
                        check_rename(held_word, held_pc, held_id);
                    end
                end
                default: apply_cdb(stim[n].data[10:8], stim[n].data[4:0]);
            endcase
            $display("test %0d %s: %0d checks, %0d errors", n, kind_name[stim[n].kind],
                     checks - c0, errors - e0);
        end

        $display("%0d tests, %0d checks, %0d errors", stim.size(), checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
